// File: rtl/mont_pkg.sv
`default_nettype none

package mont_pkg;

    // Default operand and adder limb widths
    localparam int DEFAULT_WIDTH      = 1024;
    localparam int DEFAULT_LIMB_WIDTH = 64;

    // One radix-4 digit
    typedef logic [1:0] digit_t;

    // Operand added to (or subtracted from) the accumulator
    typedef enum logic [2:0] {
        ADD_ZERO,
        ADD_B,
        ADD_M,
        ADD_B_DIGIT,
        ADD_M_DIGIT
    } addend_sel_t;

    // Controller sequencing states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TRIPLE_B,
        ST_TRIPLE_M,
        ST_MUL_B,
        ST_MUL_M,
        ST_REDUCE_SUB,
        ST_REDUCE_ADD,
        ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/mont_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mont_ctrl_if;
    import mont_pkg::*;

    // Controller to datapath
    logic        load;
    logic        clear_acc;
    addend_sel_t addend_sel;
    logic        subtract;
    logic        add_start;
    logic        shift_acc;
    logic        shift_a;
    logic        store_b3;
    logic        store_m3;

    // Datapath to controller
    logic        add_done;
    logic        acc_negative;

    modport ctrl (
        output load, clear_acc, addend_sel, subtract, add_start,
        output shift_acc, shift_a, store_b3, store_m3,
        input  add_done, acc_negative
    );

    modport dp (
        input  load, clear_acc, addend_sel, subtract, add_start,
        input  shift_acc, shift_a, store_b3, store_m3,
        output add_done, acc_negative
    );

endinterface

`default_nettype wire

// File: rtl/limb_adder.sv
`timescale 1ns/100ps
`default_nettype none

module limb_adder #(
    parameter int WIDTH      = mont_pkg::DEFAULT_WIDTH,
    parameter int LIMB_WIDTH = mont_pkg::DEFAULT_LIMB_WIDTH
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    input  logic                        subtract,
    input  logic [WIDTH+LIMB_WIDTH-1:0] op_a,
    input  logic [WIDTH+LIMB_WIDTH-1:0] op_b,
    output logic [WIDTH+LIMB_WIDTH-1:0] sum,
    output logic                        done
);

    localparam int ACC_W = WIDTH + LIMB_WIDTH;
    localparam int LIMBS = WIDTH / LIMB_WIDTH + 1;
    localparam int CNT_W = $clog2(LIMBS);

    typedef logic [ACC_W-1:0] acc_t;
    typedef logic [WIDTH-1:0] operand_t;

    acc_t               opa_q;
    acc_t               opb_q;
    operand_t           low_q;
    logic               carry_q;
    logic               busy;
    logic [CNT_W-1:0]   limb_cnt;
    logic [LIMB_WIDTH:0] limb_sum;
    logic               last_limb;

    // Current limb, least significant first
    assign limb_sum = {1'b0, opa_q[LIMB_WIDTH-1:0]}
                    + {1'b0, opb_q[LIMB_WIDTH-1:0]}
                    + {{LIMB_WIDTH{1'b0}}, carry_q};

    assign last_limb = busy && (limb_cnt == CNT_W'(LIMBS - 1));
    assign done      = last_limb;

    // Top limb comes straight from the limb adder in the done cycle
    assign sum = {limb_sum[LIMB_WIDTH-1:0], low_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            limb_cnt <= '0;
            carry_q  <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            limb_cnt <= '0;
            // Two's complement subtract via inverted operand and carry in
            carry_q  <= subtract;
        end else if (busy) begin
            carry_q  <= limb_sum[LIMB_WIDTH];
            limb_cnt <= limb_cnt + 1'b1;
            if (last_limb) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opa_q <= op_a;
            opb_q <= subtract ? ~op_b : op_b;
        end else if (busy) begin
            opa_q <= {{LIMB_WIDTH{1'b0}}, opa_q[ACC_W-1:LIMB_WIDTH]};
            opb_q <= {{LIMB_WIDTH{1'b0}}, opb_q[ACC_W-1:LIMB_WIDTH]};
            // Finished limbs enter from the top and move down
            low_q <= {limb_sum[LIMB_WIDTH-1:0], low_q[WIDTH-1:LIMB_WIDTH]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/mont_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module mont_datapath #(
    parameter int WIDTH      = mont_pkg::DEFAULT_WIDTH,
    parameter int LIMB_WIDTH = mont_pkg::DEFAULT_LIMB_WIDTH
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    mont_ctrl_if.dp          ctl,
    output logic [WIDTH-1:0] result
);
    import mont_pkg::*;

    localparam int ACC_W = WIDTH + LIMB_WIDTH;

    typedef logic [WIDTH-1:0] operand_t;
    typedef logic [ACC_W-1:0] acc_t;

    operand_t a;
    operand_t b;
    operand_t m;
    acc_t     b3;
    acc_t     m3;
    acc_t     c;

    acc_t     b_ext;
    acc_t     m_ext;
    acc_t     b_digit_add;
    acc_t     m_digit_add;
    acc_t     addend;
    acc_t     sum;
    digit_t   a_digit;
    digit_t   q_digit;

    assign b_ext = acc_t'(b);
    assign m_ext = acc_t'(m);

    assign a_digit = a[1:0];

    // Quotient digit clears the two low bits of c + q*M
    // For M = 3 mod 4 this is c mod 4, for M = 1 mod 4 it is 3c mod 4
    assign q_digit = m[1] ? c[1:0] : {c[1] ^ c[0], c[0]};

    always_comb begin
        case (a_digit)
            2'd0:    b_digit_add = '0;
            2'd1:    b_digit_add = b_ext;
            2'd2:    b_digit_add = b_ext << 1;
            default: b_digit_add = b3;
        endcase
    end

    always_comb begin
        case (q_digit)
            2'd0:    m_digit_add = '0;
            2'd1:    m_digit_add = m_ext;
            2'd2:    m_digit_add = m_ext << 1;
            default: m_digit_add = m3;
        endcase
    end

    always_comb begin
        case (ctl.addend_sel)
            ADD_B:       addend = b_ext;
            ADD_M:       addend = m_ext;
            ADD_B_DIGIT: addend = b_digit_add;
            ADD_M_DIGIT: addend = m_digit_add;
            default:     addend = '0;
        endcase
    end

    limb_adder #(
        .WIDTH      (WIDTH),
        .LIMB_WIDTH (LIMB_WIDTH)
    ) u_adder (
        .clk      (clk),
        .resetn   (resetn),
        .start    (ctl.add_start),
        .subtract (ctl.subtract),
        .op_a     (c),
        .op_b     (addend),
        .sum      (sum),
        .done     (ctl.add_done)
    );

    // Sign of the fresh sum drives the correction loop
    assign ctl.acc_negative = sum[ACC_W-1];

    always_ff @(posedge clk) begin
        if (ctl.load) begin
            a <= in_a;
            b <= in_b;
            m <= in_m;
        end else if (ctl.add_done && ctl.shift_a) begin
            a <= {2'b00, a[WIDTH-1:2]};
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.add_done && ctl.store_b3) begin
            b3 <= sum;
        end
        if (ctl.add_done && ctl.store_m3) begin
            m3 <= sum;
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (ctl.load) begin
            c <= '0;
        end else if (ctl.add_done) begin
            if (ctl.clear_acc) begin
                c <= '0;
            end else if (ctl.shift_acc) begin
                // Low two bits are zero here, sum is non-negative
                c <= {2'b00, sum[ACC_W-1:2]};
            end else begin
                c <= sum;
            end
        end
    end

    assign result = c[WIDTH-1:0];

endmodule

`default_nettype wire

// File: rtl/mont_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mont_ctrl #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    mont_ctrl_if.ctrl  ctl,
    output logic       done
);
    import mont_pkg::*;

    localparam int DIGITS = WIDTH / 2;
    localparam int CNT_W  = $clog2(DIGITS);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    logic [CNT_W-1:0] digit_cnt;
    logic [CNT_W-1:0] cnt_next;
    logic             issue_q;
    logic             issue_next;
    logic             triple_last;
    logic             digit_last;

    // Same counter tracks the three passes of each triple build
    assign triple_last = (digit_cnt == CNT_W'(2));
    assign digit_last  = (digit_cnt == CNT_W'(DIGITS - 1));

    // Next addition starts one cycle after the previous done
    assign ctl.add_start = issue_q;
    assign done          = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            digit_cnt <= '0;
            issue_q   <= 1'b0;
        end else begin
            state     <= state_next;
            digit_cnt <= cnt_next;
            issue_q   <= issue_next;
        end
    end

    always_comb begin
        state_next     = state;
        cnt_next       = digit_cnt;
        issue_next     = 1'b0;
        ctl.load       = 1'b0;
        ctl.clear_acc  = 1'b0;
        ctl.addend_sel = ADD_ZERO;
        ctl.subtract   = 1'b0;
        ctl.shift_acc  = 1'b0;
        ctl.shift_a    = 1'b0;
        ctl.store_b3   = 1'b0;
        ctl.store_m3   = 1'b0;

        case (state)
            ST_IDLE: begin
                if (start) begin
                    ctl.load   = 1'b1;
                    cnt_next   = '0;
                    issue_next = 1'b1;
                    state_next = ST_TRIPLE_B;
                end
            end

            // 0 + B + B + B, kept in b3
            ST_TRIPLE_B: begin
                ctl.addend_sel = ADD_B;
                ctl.store_b3   = triple_last;
                ctl.clear_acc  = triple_last;
                if (ctl.add_done) begin
                    issue_next = 1'b1;
                    if (triple_last) begin
                        cnt_next   = '0;
                        state_next = ST_TRIPLE_M;
                    end else begin
                        cnt_next = digit_cnt + 1'b1;
                    end
                end
            end

            ST_TRIPLE_M: begin
                ctl.addend_sel = ADD_M;
                ctl.store_m3   = triple_last;
                ctl.clear_acc  = triple_last;
                if (ctl.add_done) begin
                    issue_next = 1'b1;
                    if (triple_last) begin
                        cnt_next   = '0;
                        state_next = ST_MUL_B;
                    end else begin
                        cnt_next = digit_cnt + 1'b1;
                    end
                end
            end

            ST_MUL_B: begin
                ctl.addend_sel = ADD_B_DIGIT;
                if (ctl.add_done) begin
                    issue_next = 1'b1;
                    state_next = ST_MUL_M;
                end
            end

            // Reduction step, then drop two bits of c and a
            ST_MUL_M: begin
                ctl.addend_sel = ADD_M_DIGIT;
                ctl.shift_acc  = 1'b1;
                ctl.shift_a    = 1'b1;
                if (ctl.add_done) begin
                    issue_next = 1'b1;
                    if (digit_last) begin
                        cnt_next   = '0;
                        state_next = ST_REDUCE_SUB;
                    end else begin
                        cnt_next   = digit_cnt + 1'b1;
                        state_next = ST_MUL_B;
                    end
                end
            end

            // Subtract M until the accumulator goes negative
            ST_REDUCE_SUB: begin
                ctl.addend_sel = ADD_M;
                ctl.subtract   = 1'b1;
                if (ctl.add_done) begin
                    issue_next = 1'b1;
                    if (ctl.acc_negative) begin
                        state_next = ST_REDUCE_ADD;
                    end
                end
            end

            // One add of M undoes the overshoot
            ST_REDUCE_ADD: begin
                ctl.addend_sel = ADD_M;
                if (ctl.add_done) begin
                    state_next = ST_DONE;
                end
            end

            ST_DONE: begin
                state_next = ST_IDLE;
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/montgomery_mul.sv
`timescale 1ns/100ps
`default_nettype none

module montgomery_mul #(
    parameter int WIDTH      = mont_pkg::DEFAULT_WIDTH,
    parameter int LIMB_WIDTH = mont_pkg::DEFAULT_LIMB_WIDTH
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    output logic [WIDTH-1:0] result,
    output logic             done
);

    mont_ctrl_if ctl_if ();

    mont_ctrl #(
        .WIDTH (WIDTH)
    ) u_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .ctl    (ctl_if.ctrl),
        .done   (done)
    );

    mont_datapath #(
        .WIDTH      (WIDTH),
        .LIMB_WIDTH (LIMB_WIDTH)
    ) u_datapath (
        .clk    (clk),
        .resetn (resetn),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .ctl    (ctl_if.dp),
        .result (result)
    );

endmodule

`default_nettype wire

// File: bench/montgomery_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module montgomery_asserts #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH
) (
    input wire logic             clk,
    input wire logic             resetn,
    input wire logic             done,
    input wire logic [WIDTH-1:0] result,
    input wire logic [WIDTH-1:0] in_m,
    input wire logic             add_start,
    input wire logic             add_done
);

    logic pending;

    // Tracks an addition between add_start and add_done
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (add_start) begin
            pending <= 1'b1;
        end else if (add_done) begin
            pending <= 1'b0;
        end
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done high for two cycles");

    no_start_while_pending: assert property (@(posedge clk) disable iff (!resetn)
        add_start |-> !pending)
        else $error("add_start while an addition is pending");

    result_reduced: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (result < in_m))
        else $error("result not below the modulus");

endmodule

bind montgomery_mul montgomery_asserts #(
    .WIDTH (WIDTH)
) u_asserts (
    .clk       (clk),
    .resetn    (resetn),
    .done      (done),
    .result    (result),
    .in_m      (in_m),
    .add_start (ctl_if.add_start),
    .add_done  (ctl_if.add_done)
);

`default_nettype wire

// File: bench/tb_montgomery.sv
`timescale 1ns/100ps
`default_nettype none

module tb_montgomery;

    localparam int WIDTH        = 128;
    localparam int LIMB_WIDTH   = 32;
    localparam int LIMBS        = WIDTH / LIMB_WIDTH + 1;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int GAP_MAX      = 8;
    // Worst case digit loop plus triple builds, then room for correction passes
    localparam int OP_CYCLES    = 2 * (WIDTH / 2 + 3) * (LIMBS + 2);
    localparam int CORR_CYCLES  = 64 * (LIMBS + 2);

    typedef logic [WIDTH-1:0] operand_t;

    logic     clk;
    logic     resetn;
    logic     start;
    operand_t in_a;
    operand_t in_b;
    operand_t in_m;
    operand_t result;
    logic     done;

    string    names[$];
    operand_t vec_a[$];
    operand_t vec_b[$];
    operand_t vec_m[$];
    operand_t vec_exp[$];

    int cycle_count = 0;
    int max_cycles  = 0;
    int errors      = 0;

    montgomery_mul #(
        .WIDTH      (WIDTH),
        .LIMB_WIDTH (LIMB_WIDTH)
    ) dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Global watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (max_cycles > 0 && cycle_count >= max_cycles) begin
            stop_run("Timeout: the design did not finish within the cycle limit");
        end
    end

    task automatic check_result(input string name, input operand_t expected,
                                input operand_t actual);
        if (actual !== expected) begin
            errors++;
            stop_run($sformatf("** Error: test %s expected %h actual %h",
                               name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            stop_run($sformatf("** Error: test %s expected %b actual %b",
                               name, expected, actual));
        end
    endtask

    task automatic load_vectors();
        int       fd;
        int       code;
        string    line;
        string    tag;
        operand_t a;
        operand_t b;
        operand_t m;
        operand_t e;
        fd = $fopen("bench/montgomery_testdata.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open the test data file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Skip comment and blank lines
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%s %h %h %h %h", tag, a, b, m, e);
                if (code == 5) begin
                    names.push_back(tag);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_m.push_back(m);
                    vec_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
        if (names.size() < 3) begin
            stop_run("Too few test vectors in the test data file");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetn = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("reset_done_low", 1'b0, done);
        end
        resetn = 1'b1;
    endtask

    task automatic start_op(input int idx);
        @(negedge clk);
        in_a  = vec_a[idx];
        in_b  = vec_b[idx];
        in_m  = vec_m[idx];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    // Result is sampled in the done cycle, then done must drop
    task automatic finish_op(input int idx);
        wait_for_done();
        check_result(names[idx], vec_exp[idx], result);
        @(negedge clk);
        check_flag({names[idx], "_done_pulse"}, 1'b0, done);
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % GAP_MAX;
        repeat (n) @(negedge clk);
    endtask

    initial begin
        void'($urandom(86660));
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;

        load_vectors();
        max_cycles = (names.size() + 4) * (OP_CYCLES + CORR_CYCLES + GAP_MAX)
                   + 4 * RESET_CYCLES;
        apply_reset();

        // File vectors back to back with random idle gaps
        for (int i = 0; i < names.size(); i++) begin
            idle_gap();
            start_op(i);
            finish_op(i);
        end

        // Second start with new operands while busy must be ignored
        idle_gap();
        start_op(0);
        repeat (30) @(negedge clk);
        in_a  = ~vec_a[0];
        in_b  = ~vec_b[0];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        finish_op(0);

        // Reset in the middle of an operation
        idle_gap();
        start_op(1);
        repeat (50) @(negedge clk);
        apply_reset();
        repeat (20) begin
            @(negedge clk);
            check_flag("after_reset_done_low", 1'b0, done);
        end
        // Another vector, so a surviving old operation gives a wrong result
        start_op(2);
        finish_op(2);

        if (errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run("Errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

// File: bench/montgomery_testdata.txt
# Columns: name a b m expected, all values in hex
# expected = a * b * 2^-128 mod m
t01_m1_wide 2 3 80000000000000000000000000000001 7ffffffffffffffffffffffffffffffe
t02_m1_pow64 10000000000000000 10000000000000000 80000000000000000000000000000001 1
t03_m1_pow 10000000000000000000000000 40000000000000000000000 80000000000000000000000000000001 4000000000000000
t04_m3_wide 3 5 7fffffffffffffffffffffffffffffff 40000000000000000000000000000007
t05_m3_pow64 10000000000000000 10000000000000000 7fffffffffffffffffffffffffffffff 1
t06_m3_neg 7ffffffffffffffffffffffffffffffe 7ffffffffffffffffffffffffffffffe 7fffffffffffffffffffffffffffffff 40000000000000000000000000000000
t07_m3_ones fffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffe ffffffffffffffffffffffffffffffff 1
t08_zero_a 0 123456789abcdef0fedcba9876543210 80000000000000000000000000000001 0
t09_corr_m5 80000000000000000000000000000000 29 5 3
t10_corr_m7 80000000000000000000000000000000 45 7 3
t11_corr_m13 c0000000000000000000000000000000 64 d a
t12_corr_m11 ffffffffffffffffffffffffffffffff 20 b 3

// File: build.f
rtl/mont_pkg.sv
rtl/mont_ctrl_if.sv
rtl/limb_adder.sv
rtl/mont_datapath.sv
rtl/mont_ctrl.sv
rtl/montgomery_mul.sv
bench/montgomery_asserts.sv
bench/tb_montgomery.sv

// File: run.sh
#!/bin/sh
# Build and run the Montgomery multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_montgomery -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi
